// File: Bender.yml
package:
  name: decode_stage

sources:
  - rv_isa_pkg.sv
  - pipe_pkg.sv
  - inst_decoder.sv
  - imm_gen.sv
  - reg_file.sv
  - operand_fwd.sv
  - decode_ctrl.sv
  - decode_stage.sv
  - target: test
    files:
      - tb_decode_stage.sv

// File: decode_ctrl.sv
`timescale 1ns/1ps

module decode_ctrl (
	input  logic              clock,
	input  logic              rst_n,
	input  logic              in_valid,
	output logic              in_ready,
	input  rv_isa_pkg::word_t pc,
	input  pipe_pkg::dec_t    dec,
	input  rv_isa_pkg::word_t imm,
	input  rv_isa_pkg::word_t src1,
	input  rv_isa_pkg::word_t src2,
	input  logic              load_stall,
	input  logic              flush,
	output logic              out_valid,
	input  logic              out_ready,
	output pipe_pkg::issue_t  issue
);
	import pipe_pkg::*;

	logic   held_wr;
	logic   self_hazard;
	logic   xfer;
	issue_t issue_d;

	// the held instruction writes a register that execute has not produced yet.
	assign held_wr     = out_valid & issue.reg_wen & (issue.rd != '0);
	assign self_hazard = held_wr &
	                     ((dec.need_rs1 & (issue.rd == dec.rs1)) |
	                      (dec.need_rs2 & (issue.rd == dec.rs2)));

	assign in_ready = ~(load_stall | self_hazard) & (out_ready | ~out_valid);
	assign xfer     = in_valid & in_ready;

	always_comb begin
		issue_d.pc        = pc;
		issue_d.op_class  = dec.op_class;
		issue_d.funct3    = dec.funct3;
		issue_d.funct7_5  = dec.funct7_5;
		issue_d.rd        = dec.rd;
		issue_d.src1      = src1;
		issue_d.src2      = src2;
		issue_d.imm       = imm;
		issue_d.reg_wen   = dec.reg_wen;
		issue_d.is_fencei = dec.is_fencei;
		issue_d.is_ecall  = dec.is_ecall;
		issue_d.is_mret   = dec.is_mret;
	end

	always_ff @(posedge clock) begin
		if (!rst_n)
			out_valid <= 1'b0;
		else if (flush)
			out_valid <= 1'b0;  // wrong path, drop it.
		else if (xfer)
			out_valid <= 1'b1;
		else if (out_ready)
			out_valid <= 1'b0;
	end

	always_ff @(posedge clock) begin
		if (xfer)
			issue <= issue_d;
	end

endmodule

// File: decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
	input  logic              clock,
	input  logic              rst_n,
	input  logic              in_valid,
	output logic              in_ready,
	input  rv_isa_pkg::word_t instr,
	input  rv_isa_pkg::word_t pc,
	input  pipe_pkg::bypass_t ex_byp,
	input  pipe_pkg::bypass_t mem_byp,
	input  pipe_pkg::wb_t     wb,
	input  logic              flush,
	output logic              out_valid,
	input  logic              out_ready,
	output pipe_pkg::issue_t  issue
);
	import rv_isa_pkg::*;
	import pipe_pkg::*;

	dec_t  dec;
	word_t imm;
	word_t rdata1;
	word_t rdata2;
	word_t src1;
	word_t src2;
	logic  load_stall;

	inst_decoder i_inst_decoder (
		.instr (instr),
		.dec   (dec)
	);

	imm_gen i_imm_gen (
		.instr (instr),
		.fmt   (dec.fmt),
		.imm   (imm)
	);

	reg_file i_reg_file (
		.clock  (clock),
		.rst_n  (rst_n),
		.raddr1 (dec.rs1),
		.raddr2 (dec.rs2),
		.rdata1 (rdata1),
		.rdata2 (rdata2),
		.wb     (wb)
	);

	operand_fwd i_operand_fwd (
		.dec        (dec),
		.rdata1     (rdata1),
		.rdata2     (rdata2),
		.ex_byp     (ex_byp),
		.mem_byp    (mem_byp),
		.src1       (src1),
		.src2       (src2),
		.load_stall (load_stall)
	);

	decode_ctrl i_decode_ctrl (
		.clock      (clock),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_ready   (in_ready),
		.pc         (pc),
		.dec        (dec),
		.imm        (imm),
		.src1       (src1),
		.src2       (src2),
		.load_stall (load_stall),
		.flush      (flush),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.issue      (issue)
	);

endmodule

// File: imm_gen.sv
`timescale 1ns/1ps

module imm_gen (
	input  rv_isa_pkg::word_t instr,
	input  rv_isa_pkg::fmt_t  fmt,
	output rv_isa_pkg::word_t imm
);
	import rv_isa_pkg::*;

	logic is_s;
	logic is_b;
	logic is_u;
	logic is_j;

	assign is_s = fmt[FMT_S];
	assign is_b = fmt[FMT_B];
	assign is_u = fmt[FMT_U];
	assign is_j = fmt[FMT_J];

	// anything not S, B, U or J takes the I layout, R included.
	assign imm[31]    = instr[31];
	assign imm[30:20] = is_u ? instr[30:20] : {11{instr[31]}};
	assign imm[19:12] = (is_u | is_j) ? instr[19:12] : {8{instr[31]}};
	assign imm[11]    = is_b ? instr[7] :
	                    is_u ? 1'b0 :
	                    is_j ? instr[20] :
	                    instr[31];
	assign imm[10:5]  = is_u ? 6'b0 : instr[30:25];
	assign imm[4:1]   = is_u ? 4'b0 :
	                    (is_s | is_b) ? instr[11:8] :
	                    instr[24:21];   // I and J share these bits.
	assign imm[0]     = is_s ? instr[7] :
	                    (is_b | is_u | is_j) ? 1'b0 :
	                    instr[20];

endmodule

// File: inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
	input  rv_isa_pkg::word_t instr,
	output pipe_pkg::dec_t    dec
);
	import rv_isa_pkg::*;

	logic [4:0] opc;
	logic [2:0] funct3;
	op_class_t  cls;
	fmt_t       fmt;
	logic       need_rs2;
	logic       csr_nowb;

	assign opc    = instr[6:2];
	assign funct3 = instr[14:12];

	// one class per opcode, unknown opcodes give all zero.
	assign cls[CLS_LUI]   = (opc == OPC_LUI);
	assign cls[CLS_AUIPC] = (opc == OPC_AUIPC);
	assign cls[CLS_JAL]   = (opc == OPC_JAL);
	assign cls[CLS_JALR]  = (opc == OPC_JALR);
	assign cls[CLS_BEQ]   = (opc == OPC_BEQ);
	assign cls[CLS_LW]    = (opc == OPC_LW);
	assign cls[CLS_SW]    = (opc == OPC_SW);
	assign cls[CLS_ADDI]  = (opc == OPC_ADDI);
	assign cls[CLS_ADD]   = (opc == OPC_ADD);
	assign cls[CLS_CSR]   = (opc == OPC_CSR);

	assign fmt[FMT_R] = cls[CLS_ADD];
	assign fmt[FMT_I] = cls[CLS_JALR] | cls[CLS_LW] | cls[CLS_ADDI] | cls[CLS_CSR];
	assign fmt[FMT_S] = cls[CLS_SW];
	assign fmt[FMT_B] = cls[CLS_BEQ];
	assign fmt[FMT_U] = cls[CLS_LUI] | cls[CLS_AUIPC];
	assign fmt[FMT_J] = cls[CLS_JAL];

	// funct3 zero on the system opcode is ecall, ebreak or mret.
	assign csr_nowb = cls[CLS_CSR] & (funct3 == 3'b000);
	assign need_rs2 = cls[CLS_BEQ] | cls[CLS_SW] | cls[CLS_ADD];

	always_comb begin
		dec.op_class  = cls;
		dec.fmt       = fmt;
		dec.funct3    = funct3;
		dec.funct7_5  = instr[30];
		dec.rd        = instr[10:7];   // bit 11 unused in rv32e.
		dec.rs1       = instr[18:15];
		dec.rs2       = instr[23:20];
		dec.reg_wen   = fmt[FMT_R] | fmt[FMT_U] | fmt[FMT_J] | (fmt[FMT_I] & ~csr_nowb);
		dec.need_rs2  = need_rs2;
		dec.need_rs1  = need_rs2 | cls[CLS_JALR] | cls[CLS_LW] | cls[CLS_ADDI] | cls[CLS_CSR];
		dec.is_ecall  = (instr == INSTR_ECALL);
		dec.is_mret   = (instr == INSTR_MRET);
		dec.is_fencei = (opc == OPC_FENCE);
	end

endmodule

// File: operand_fwd.sv
`timescale 1ns/1ps

module operand_fwd (
	input  pipe_pkg::dec_t    dec,
	input  rv_isa_pkg::word_t rdata1,
	input  rv_isa_pkg::word_t rdata2,
	input  pipe_pkg::bypass_t ex_byp,
	input  pipe_pkg::bypass_t mem_byp,
	output rv_isa_pkg::word_t src1,
	output rv_isa_pkg::word_t src2,
	output logic              load_stall
);
	import rv_isa_pkg::*;
	import pipe_pkg::*;

	logic ex_hit1;
	logic ex_hit2;
	logic mem_hit1;
	logic mem_hit2;

	// a stage result that this operand would read.
	function automatic logic byp_hit(
		input bypass_t  byp,
		input reg_idx_t idx,
		input logic     need
	);
		return byp.valid & byp.reg_wen & (byp.rd != '0) & (byp.rd == idx) & need;
	endfunction

	assign ex_hit1  = byp_hit(ex_byp, dec.rs1, dec.need_rs1);
	assign ex_hit2  = byp_hit(ex_byp, dec.rs2, dec.need_rs2);
	assign mem_hit1 = byp_hit(mem_byp, dec.rs1, dec.need_rs1);
	assign mem_hit2 = byp_hit(mem_byp, dec.rs2, dec.need_rs2);

	// youngest result wins.
	assign src1 = ex_hit1  ? ex_byp.value :
	              mem_hit1 ? mem_byp.value :
	              rdata1;
	assign src2 = ex_hit2  ? ex_byp.value :
	              mem_hit2 ? mem_byp.value :
	              rdata2;

	// load data is not there yet, hold the instruction.
	assign load_stall = (ex_byp.is_load & (ex_hit1 | ex_hit2)) |
	                    (mem_byp.is_load & (mem_hit1 | mem_hit2));

endmodule

// File: pipe_pkg.sv
package pipe_pkg;

	// fields pulled out of one instruction by the decoder.
	typedef struct packed {
		rv_isa_pkg::op_class_t op_class;
		rv_isa_pkg::fmt_t      fmt;
		logic [2:0]            funct3;
		logic                  funct7_5;
		rv_isa_pkg::reg_idx_t  rd;
		rv_isa_pkg::reg_idx_t  rs1;
		rv_isa_pkg::reg_idx_t  rs2;
		logic                  reg_wen;
		logic                  need_rs1;
		logic                  need_rs2;
		logic                  is_ecall;
		logic                  is_mret;
		logic                  is_fencei;
	} dec_t;

	// result a later stage offers for forwarding.
	typedef struct packed {
		logic                 valid;
		logic                 reg_wen;
		logic                 is_load;  // value not ready yet.
		rv_isa_pkg::reg_idx_t rd;
		rv_isa_pkg::word_t    value;
	} bypass_t;

	typedef struct packed {
		logic                 en;
		rv_isa_pkg::reg_idx_t rd;
		rv_isa_pkg::word_t    value;
	} wb_t;

	// what decode hands to execute.
	typedef struct packed {
		rv_isa_pkg::word_t     pc;
		rv_isa_pkg::op_class_t op_class;
		logic [2:0]            funct3;
		logic                  funct7_5;
		rv_isa_pkg::reg_idx_t  rd;
		rv_isa_pkg::word_t     src1;
		rv_isa_pkg::word_t     src2;
		rv_isa_pkg::word_t     imm;
		logic                  reg_wen;
		logic                  is_fencei;
		logic                  is_ecall;
		logic                  is_mret;
	} issue_t;

endpackage

// File: project.f
rv_isa_pkg.sv
pipe_pkg.sv
inst_decoder.sv
imm_gen.sv
reg_file.sv
operand_fwd.sv
decode_ctrl.sv
decode_stage.sv
tb_decode_stage.sv

// File: reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input  logic                 clock,
	input  logic                 rst_n,
	input  rv_isa_pkg::reg_idx_t raddr1,
	input  rv_isa_pkg::reg_idx_t raddr2,
	output rv_isa_pkg::word_t    rdata1,
	output rv_isa_pkg::word_t    rdata2,
	input  pipe_pkg::wb_t        wb
);
	import rv_isa_pkg::*;

	word_t regs [NUM_REGS];

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.en && wb.rd != '0) begin
			regs[wb.rd] <= wb.value;
		end
	end

	// x0 reads zero, a write to the same register passes straight through.
	assign rdata1 = (raddr1 == '0) ? '0 :
	                (wb.en && wb.rd == raddr1) ? wb.value :
	                regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 :
	                (wb.en && wb.rd == raddr2) ? wb.value :
	                regs[raddr2];

endmodule

// File: rv_isa_pkg.sv
package rv_isa_pkg;

	localparam int XLEN        = 32;
	localparam int REG_IDX_W   = 4;                // rv32e, x0 to x15.
	localparam int NUM_REGS    = 1 << REG_IDX_W;
	localparam int NUM_CLASSES = 10;
	localparam int NUM_FMTS    = 6;

	typedef logic [XLEN-1:0]        word_t;
	typedef logic [REG_IDX_W-1:0]   reg_idx_t;
	typedef logic [NUM_CLASSES-1:0] op_class_t;  // one-hot.
	typedef logic [NUM_FMTS-1:0]    fmt_t;       // one-hot.

	// operation class bit positions.
	localparam int CLS_LUI   = 0;
	localparam int CLS_AUIPC = 1;
	localparam int CLS_JAL   = 2;
	localparam int CLS_JALR  = 3;
	localparam int CLS_BEQ   = 4;  // all conditional branches.
	localparam int CLS_LW    = 5;  // all loads.
	localparam int CLS_SW    = 6;  // all stores.
	localparam int CLS_ADDI  = 7;
	localparam int CLS_ADD   = 8;
	localparam int CLS_CSR   = 9;  // system opcode, incl. ecall and mret.

	// format bit positions.
	localparam int FMT_R = 0;
	localparam int FMT_I = 1;
	localparam int FMT_S = 2;
	localparam int FMT_B = 3;
	localparam int FMT_U = 4;
	localparam int FMT_J = 5;

	// instruction bits 6 to 2.
	localparam logic [4:0] OPC_LUI   = 5'b01101;
	localparam logic [4:0] OPC_AUIPC = 5'b00101;
	localparam logic [4:0] OPC_JAL   = 5'b11011;
	localparam logic [4:0] OPC_JALR  = 5'b11001;
	localparam logic [4:0] OPC_BEQ   = 5'b11000;
	localparam logic [4:0] OPC_LW    = 5'b00000;
	localparam logic [4:0] OPC_SW    = 5'b01000;
	localparam logic [4:0] OPC_ADDI  = 5'b00100;
	localparam logic [4:0] OPC_ADD   = 5'b01100;
	localparam logic [4:0] OPC_CSR   = 5'b11100;
	localparam logic [4:0] OPC_FENCE = 5'b00011;

	// full-word system encodings.
	localparam word_t INSTR_ECALL = 32'h0000_0073;
	localparam word_t INSTR_MRET  = 32'h3020_0073;

endpackage

// File: tb_decode_stage.sv
`timescale 1ns/1ps

module tb_decode_stage;
	import rv_isa_pkg::*;
	import pipe_pkg::*;

	logic    clock;
	logic    rst_n;
	logic    in_valid;
	logic    in_ready;
	word_t   instr;
	word_t   pc;
	bypass_t ex_byp;
	bypass_t mem_byp;
	wb_t     wb;
	logic    flush;
	logic    out_valid;
	logic    out_ready;
	issue_t  issue;

	word_t   model_regs [NUM_REGS];
	logic    exp_valid;
	issue_t  exp_issue;
	word_t   ins;

	decode_stage i_decode_stage (
		.clock     (clock),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.instr     (instr),
		.pc        (pc),
		.ex_byp    (ex_byp),
		.mem_byp   (mem_byp),
		.wb        (wb),
		.flush     (flush),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.issue     (issue)
	);

	always #4 clock = ~clock;

	task automatic stop_run(input string why);
		$display("*** TEST FAILED ***");
		$fatal(1, "%s", why);
	endtask

	task automatic fail_value(input string name, input logic [159:0] got, input logic [159:0] exp);
		$display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
		stop_run("value mismatch");
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_value(name, got, exp);
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp)
			fail_value(name, got, exp);
	endtask

	task automatic check_issue(input issue_t got, input issue_t exp);
		check_word("issue.pc", got.pc, exp.pc);
		check_word("issue.src1", got.src1, exp.src1);
		check_word("issue.src2", got.src2, exp.src2);
		check_word("issue.imm", got.imm, exp.imm);
		if (got !== exp)
			fail_value("issue", got, exp);  // control fields.
	endtask

	function automatic logic byp_match(input bypass_t b, input reg_idx_t idx, input logic need);
		return need && b.valid && b.reg_wen && b.rd != 0 && b.rd == idx;
	endfunction

	// youngest stage first, then the register file with write-through.
	function automatic word_t pick_operand(input reg_idx_t idx, input logic need, output logic ld);
		ld = (byp_match(ex_byp, idx, need) && ex_byp.is_load) ||
		     (byp_match(mem_byp, idx, need) && mem_byp.is_load);
		if (byp_match(ex_byp, idx, need))
			return ex_byp.value;
		if (byp_match(mem_byp, idx, need))
			return mem_byp.value;
		if (idx == 0)
			return '0;
		if (wb.en && wb.rd == idx)
			return wb.value;
		return model_regs[idx];
	endfunction

	function automatic issue_t ref_decode(input word_t w, input word_t pc_v, output logic rdy);
		issue_t   r;
		reg_idx_t rs1;
		reg_idx_t rs2;
		logic     is_i;
		logic     n1;
		logic     n2;
		logic     ld1;
		logic     ld2;
		logic     hazard;
		r = '0;
		rs1 = w[18:15];
		rs2 = w[23:20];
		case (w[6:2])
			OPC_LUI:   r.op_class[CLS_LUI] = 1'b1;
			OPC_AUIPC: r.op_class[CLS_AUIPC] = 1'b1;
			OPC_JAL:   r.op_class[CLS_JAL] = 1'b1;
			OPC_JALR:  r.op_class[CLS_JALR] = 1'b1;
			OPC_BEQ:   r.op_class[CLS_BEQ] = 1'b1;
			OPC_LW:    r.op_class[CLS_LW] = 1'b1;
			OPC_SW:    r.op_class[CLS_SW] = 1'b1;
			OPC_ADDI:  r.op_class[CLS_ADDI] = 1'b1;
			OPC_ADD:   r.op_class[CLS_ADD] = 1'b1;
			OPC_CSR:   r.op_class[CLS_CSR] = 1'b1;
			default:   ;
		endcase
		is_i = r.op_class[CLS_JALR] | r.op_class[CLS_LW] | r.op_class[CLS_ADDI] |
		       r.op_class[CLS_CSR];
		n2 = r.op_class[CLS_BEQ] | r.op_class[CLS_SW] | r.op_class[CLS_ADD];
		n1 = n2 | is_i;
		r.pc = pc_v;
		r.funct3 = w[14:12];
		r.funct7_5 = w[30];
		r.rd = w[10:7];
		r.reg_wen = r.op_class[CLS_ADD] | r.op_class[CLS_LUI] | r.op_class[CLS_AUIPC] |
		            r.op_class[CLS_JAL] | (is_i & !(r.op_class[CLS_CSR] && w[14:12] == 3'b000));
		if (r.op_class[CLS_SW])
			r.imm = {{20{w[31]}}, w[31:25], w[11:7]};
		else if (r.op_class[CLS_BEQ])
			r.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
		else if (r.op_class[CLS_LUI] | r.op_class[CLS_AUIPC])
			r.imm = {w[31:12], 12'h000};
		else if (r.op_class[CLS_JAL])
			r.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
		else
			r.imm = {{20{w[31]}}, w[31:20]};
		r.is_ecall = (w == INSTR_ECALL);
		r.is_mret = (w == INSTR_MRET);
		r.is_fencei = (w[6:2] == OPC_FENCE);
		r.src1 = pick_operand(rs1, n1, ld1);
		r.src2 = pick_operand(rs2, n2, ld2);
		hazard = exp_valid && exp_issue.reg_wen && exp_issue.rd != 0 &&
		         ((n1 && exp_issue.rd == rs1) || (n2 && exp_issue.rd == rs2));
		rdy = !(ld1 || ld2 || hazard) && (out_ready || !exp_valid);
		return r;
	endfunction

	// kinds 0 to 9 follow the class order, then ecall, mret and fence.i.
	function automatic word_t make_instr(input int kind);
		word_t w;
		w = $urandom;
		case (kind)
			0:       w[6:2] = OPC_LUI;
			1:       w[6:2] = OPC_AUIPC;
			2:       w[6:2] = OPC_JAL;
			3:       w[6:2] = OPC_JALR;
			4:       w[6:2] = OPC_BEQ;
			5:       w[6:2] = OPC_LW;
			6:       w[6:2] = OPC_SW;
			7:       w[6:2] = OPC_ADDI;
			8:       w[6:2] = OPC_ADD;
			9:       w[6:2] = OPC_CSR;
			10:      w = INSTR_ECALL;
			11:      w = INSTR_MRET;
			default: w = {w[31:15], 3'b001, w[11:7], OPC_FENCE, 2'b11};
		endcase
		w[1:0] = 2'b11;
		return w;
	endfunction

	function automatic bypass_t rand_byp(input word_t w);
		bypass_t b;
		b.valid = ($urandom_range(0, 3) != 0);
		b.reg_wen = ($urandom_range(0, 3) != 0);
		b.is_load = 1'b0;
		case ($urandom_range(0, 3))
			0:       b.rd = w[18:15];
			1:       b.rd = w[23:20];
			2:       b.rd = '0;
			default: b.rd = reg_idx_t'($urandom);
		endcase
		b.value = $urandom;
		return b;
	endfunction

	always begin
		issue_t nxt;
		logic   rdy;
		@(posedge clock);
		nxt = ref_decode(instr, pc, rdy);
		if (!rst_n) begin
			exp_valid = 1'b0;
			for (int i = 0; i < NUM_REGS; i++)
				model_regs[i] = '0;
		end else begin
			check_bit("in_ready", in_ready, rdy);
			if (in_valid && rdy)
				exp_issue = nxt;
			if (flush)
				exp_valid = 1'b0;
			else if (in_valid && rdy)
				exp_valid = 1'b1;
			else if (out_ready)
				exp_valid = 1'b0;
			if (wb.en && wb.rd != 0)
				model_regs[wb.rd] = wb.value;
		end
		#1;
		check_bit("out_valid", out_valid, exp_valid);
		if (exp_valid)
			check_issue(issue, exp_issue);
	end

	task automatic present(input word_t w);
		instr = w;
		pc = pc + 4;
		in_valid = 1'b1;
	endtask

	task automatic wait_xfer();
		int cycles;
		cycles = 0;
		do begin
			@(posedge clock);
			cycles++;
		end while (!in_ready && cycles < 50);
		if (!in_ready)
			stop_run("timeout: instruction not accepted within 50 cycles");
		@(negedge clock);
		in_valid = 1'b0;
	endtask

	task automatic send(input word_t w);
		present(w);
		wait_xfer();
	endtask

	task automatic hold_stalled(input int n);
		repeat (n) begin
			@(posedge clock);
			check_bit("in_ready", in_ready, 1'b0);
		end
		@(negedge clock);
	endtask

	task automatic idle(input int n);
		in_valid = 1'b0;
		repeat (n) @(negedge clock);
	endtask

	initial begin
		void'($urandom(60));
		clock = 1'b0;
		rst_n = 1'b0;
		in_valid = 1'b0;
		instr = INSTR_ECALL;
		pc = 32'h0000_1000;
		ex_byp = '0;
		mem_byp = '0;
		wb = '0;
		flush = 1'b0;
		out_ready = 1'b1;
		exp_valid = 1'b0;
		exp_issue = '0;
		repeat (4) @(negedge clock);
		rst_n = 1'b1;

		// fill the register file, x0 included.
		for (int r = 0; r < NUM_REGS; r++) begin
			wb.en = 1'b1;
			wb.rd = reg_idx_t'(r);
			wb.value = $urandom;
			@(negedge clock);
		end

		// random decode with forwarding and writeback traffic.
		for (int n = 0; n < 200; n++) begin
			ins = make_instr($urandom_range(0, 12));
			ex_byp = rand_byp(ins);
			mem_byp = rand_byp(ins);
			wb.en = ($urandom_range(0, 1) != 0);
			wb.rd = ($urandom_range(0, 1) != 0) ? ins[18:15] : reg_idx_t'($urandom);
			wb.value = $urandom;
			send(ins);
		end
		ex_byp = '0;
		mem_byp = '0;
		wb = '0;

		// load-use on rs1 from execute, then on rs2 from memory.
		idle(2);
		ins = make_instr(8);
		ins[19:15] = 5'd3;
		ins[24:20] = 5'd6;
		ex_byp = '{1'b1, 1'b1, 1'b1, 4'd3, $urandom};
		present(ins);
		hold_stalled(3);
		ex_byp = '0;
		mem_byp = '{1'b1, 1'b1, 1'b1, 4'd6, $urandom};
		hold_stalled(3);
		mem_byp.is_load = 1'b0;  // data arrived, now forwarded.
		wait_xfer();
		mem_byp = '0;

		// dependency on the instruction still held in issue.
		ins = make_instr(7);
		ins[11:7] = 5'd9;
		send(ins);
		ins = make_instr(6);
		ins[19:15] = 5'd9;
		present(ins);
		hold_stalled(1);
		wait_xfer();

		idle(2);
		out_ready = 1'b0;
		send(make_instr(4));
		present(make_instr(0));
		hold_stalled(5);
		out_ready = 1'b1;
		wait_xfer();

		// flush while accepting, then flush of a held instruction.
		flush = 1'b1;
		send(make_instr(2));
		flush = 1'b0;
		out_ready = 1'b0;
		send(make_instr(9));
		flush = 1'b1;
		@(negedge clock);
		flush = 1'b0;
		out_ready = 1'b1;
		idle(3);

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule
